// ==== Makefile ====
TOP = tb_rv32_cpu

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f rv32_pipe.f

# The run fails with a non-zero status when the testbench calls $fatal
sim:
	verilator --binary --timing --assert --top-module $(TOP) -f rv32_pipe.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== rv32_alu.sv ====
module rv32_alu (
    input  rv32_pkg::word_t   a,
    input  rv32_pkg::word_t   b,
    input  rv32_pkg::alu_op_e op,
    output rv32_pkg::word_t   y
);
    import rv32_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            alu_add: y = a + b;
            alu_sub: y = a - b;
            alu_sll: y = a << shamt;
            alu_slt: begin
                y = {31'b0, $signed(a) < $signed(b)};
            end
            alu_sltu: begin
                y = {31'b0, a < b};
            end
            alu_xor: y = a ^ b;
            alu_srl: y = a >> shamt;
            alu_sra: y = $signed(a) >>> shamt;
            alu_or:  y = a | b;
            alu_and: y = a & b;
            default: y = a + b;
        endcase
    end

endmodule

// ==== rv32_cpu.sv ====
module rv32_cpu #(
    parameter rv32_pkg::word_t reset_pc = '0
) (
    input  logic            clk,
    input  logic            reset,
    input  rv32_pkg::word_t inst_in,
    input  rv32_pkg::word_t ram_data_in,
    output rv32_pkg::word_t pc_out,
    output rv32_pkg::word_t alu_out,
    output rv32_pkg::word_t data_out,
    output logic            mem_w
);
    import rv32_pkg::*;

    // IF and IF/ID
    word_t     pc;
    word_t     if_id_instr;
    word_t     if_id_pc;
    // ID
    reg_addr_t id_rs1;
    reg_addr_t id_rs2;
    logic      id_uses_rs1;
    logic      id_uses_rs2;
    reg_addr_t id_rd;
    logic      id_reg_write;
    word_t     id_imm;
    alu_op_e   id_alu_op;
    logic      id_alu_src_imm;
    logic      id_zero_a;
    branch_e   id_branch;
    logic      id_is_jal;
    logic      id_mem_read;
    logic      id_mem_write;
    wb_sel_e   id_wb_sel;
    word_t     id_rda;
    word_t     id_rdb;
    word_t     br_a;
    word_t     br_b;
    logic      br_taken;
    logic      redirect;
    word_t     target;
    // ID/EXE
    reg_addr_t ex_rs1;
    reg_addr_t ex_rs2;
    reg_addr_t ex_rd;
    logic      ex_reg_write;
    logic      ex_mem_read;
    logic      ex_mem_write;
    word_t     ex_pc;
    word_t     ex_rda;
    word_t     ex_rdb;
    word_t     ex_imm;
    alu_op_e   ex_alu_op;
    logic      ex_alu_src_imm;
    logic      ex_zero_a;
    wb_sel_e   ex_wb_sel;
    word_t     ex_fwd_a;
    word_t     ex_fwd_b;
    word_t     alu_a;
    word_t     alu_b;
    word_t     ex_y;
    // EXE/MEM
    reg_addr_t mem_rd;
    logic      mem_reg_write;
    logic      mem_mem_write;
    word_t     mem_y;
    word_t     mem_store_data;
    word_t     mem_pc;
    wb_sel_e   mem_wb_sel;
    word_t     mem_value;
    // MEM/WB
    reg_addr_t wb_rd;
    logic      wb_reg_write;
    word_t     wb_y;
    word_t     wb_load;
    word_t     wb_pc;
    wb_sel_e   wb_stage_sel;
    word_t     wb_data;
    // Hazard control
    fwd_sel_e  fwd_a;
    fwd_sel_e  fwd_b;
    logic      branch_fwd_a;
    logic      branch_fwd_b;
    logic      stall;

    function automatic word_t fwd_mux(fwd_sel_e sel, word_t reg_val, word_t mem_val,
                                      word_t wb_val);
        word_t val;
        case (sel)
            fwd_mem: val = mem_val;
            fwd_wb:  val = wb_val;
            default: val = reg_val;
        endcase
        return val;
    endfunction

    // Result of an instruction once its load data is known
    function automatic word_t result_mux(wb_sel_e sel, word_t alu_val, word_t load_val,
                                         word_t pc_val);
        word_t val;
        case (sel)
            wb_mem:  val = load_val;
            wb_pc4:  val = pc_val + 32'd4;
            default: val = alu_val;
        endcase
        return val;
    endfunction

    ////////////////////////////////////////
    // IF
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (!stall) begin
            pc <= redirect ? target : pc + 32'd4;
        end
    end

    assign pc_out = pc;

    // Taken transfer squashes the one wrong-path fetch
    always_ff @(posedge clk) begin
        if (reset || redirect) begin
            if_id_instr <= nop_instr;
        end else if (!stall) begin
            if_id_instr <= inst_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if_id_pc <= pc;
        end
    end

    ////////////////////////////////////////
    // ID
    ////////////////////////////////////////

    rv32_decoder decoder0 (
        .instr       (if_id_instr),
        .rs1         (id_rs1),
        .rs2         (id_rs2),
        .uses_rs1    (id_uses_rs1),
        .uses_rs2    (id_uses_rs2),
        .rd          (id_rd),
        .reg_write   (id_reg_write),
        .imm         (id_imm),
        .alu_op      (id_alu_op),
        .alu_src_imm (id_alu_src_imm),
        .zero_a      (id_zero_a),
        .branch      (id_branch),
        .is_jal      (id_is_jal),
        .mem_read    (id_mem_read),
        .mem_write   (id_mem_write),
        .wb_sel      (id_wb_sel)
    );

    rv32_regfile regfile0 (
        .clk   (clk),
        .reset (reset),
        .ra    (id_rs1),
        .rb    (id_rs2),
        .wa    (wb_rd),
        .we    (wb_reg_write),
        .wd    (wb_data),
        .rda   (id_rda),
        .rdb   (id_rdb)
    );

    rv32_hazard_unit hazard0 (
        .id_rs1        (id_rs1),
        .id_rs2        (id_rs2),
        .id_uses_rs1   (id_uses_rs1),
        .id_uses_rs2   (id_uses_rs2),
        .id_is_control (id_is_jal || id_branch != br_none),
        .ex_rs1        (ex_rs1),
        .ex_rs2        (ex_rs2),
        .ex_rd         (ex_rd),
        .ex_mem_read   (ex_mem_read),
        .mem_rd        (mem_rd),
        .wb_rd         (wb_rd),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b),
        .branch_fwd_a  (branch_fwd_a),
        .branch_fwd_b  (branch_fwd_b),
        .stall         (stall)
    );

    // Branch compare on operands forwarded from MEM
    assign br_a = branch_fwd_a ? mem_value : id_rda;
    assign br_b = branch_fwd_b ? mem_value : id_rdb;

    always_comb begin
        case (id_branch)
            br_eq:   br_taken = br_a == br_b;
            br_ne:   br_taken = br_a != br_b;
            br_lt:   br_taken = $signed(br_a) < $signed(br_b);
            br_ge:   br_taken = $signed(br_a) >= $signed(br_b);
            br_ltu:  br_taken = br_a < br_b;
            br_geu:  br_taken = br_a >= br_b;
            default: br_taken = 1'b0;
        endcase
    end

    // Decoder already picked the B or J immediate
    assign target   = if_id_pc + id_imm;
    assign redirect = !stall && (id_is_jal || br_taken);

    // Stall turns the ID/EXE slot into a bubble
    always_ff @(posedge clk) begin
        if (reset || stall) begin
            ex_rd        <= '0;
            ex_reg_write <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
        end else begin
            ex_rd        <= id_rd;
            ex_reg_write <= id_reg_write;
            ex_mem_read  <= id_mem_read;
            ex_mem_write <= id_mem_write;
        end
    end

    always_ff @(posedge clk) begin
        ex_rs1         <= id_rs1;
        ex_rs2         <= id_rs2;
        ex_pc          <= if_id_pc;
        ex_rda         <= id_rda;
        ex_rdb         <= id_rdb;
        ex_imm         <= id_imm;
        ex_alu_op      <= id_alu_op;
        ex_alu_src_imm <= id_alu_src_imm;
        ex_zero_a      <= id_zero_a;
        ex_wb_sel      <= id_wb_sel;
    end

    ////////////////////////////////////////
    // EXE
    ////////////////////////////////////////

    assign ex_fwd_a = fwd_mux(fwd_a, ex_rda, mem_value, wb_data);
    assign ex_fwd_b = fwd_mux(fwd_b, ex_rdb, mem_value, wb_data);
    assign alu_a    = ex_zero_a ? '0 : ex_fwd_a;
    assign alu_b    = ex_alu_src_imm ? ex_imm : ex_fwd_b;

    rv32_alu alu0 (
        .a  (alu_a),
        .b  (alu_b),
        .op (ex_alu_op),
        .y  (ex_y)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_rd        <= '0;
            mem_reg_write <= 1'b0;
            mem_mem_write <= 1'b0;
        end else begin
            mem_rd        <= ex_rd;
            mem_reg_write <= ex_reg_write;
            mem_mem_write <= ex_mem_write;
        end
    end

    // Store data is the forwarded rs2
    always_ff @(posedge clk) begin
        mem_y          <= ex_y;
        mem_store_data <= ex_fwd_b;
        mem_pc         <= ex_pc;
        mem_wb_sel     <= ex_wb_sel;
    end

    ////////////////////////////////////////
    // MEM and WB
    ////////////////////////////////////////

    assign alu_out   = mem_y;
    assign data_out  = mem_store_data;
    assign mem_w     = mem_mem_write;
    assign mem_value = result_mux(mem_wb_sel, mem_y, ram_data_in, mem_pc);

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_rd        <= '0;
            wb_reg_write <= 1'b0;
        end else begin
            wb_rd        <= mem_rd;
            wb_reg_write <= mem_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        wb_y         <= mem_y;
        wb_load      <= ram_data_in;
        wb_pc        <= mem_pc;
        wb_stage_sel <= mem_wb_sel;
    end

    assign wb_data = result_mux(wb_stage_sel, wb_y, wb_load, wb_pc);

endmodule

// ==== rv32_decoder.sv ====
module rv32_decoder (
    input  rv32_pkg::word_t     instr,
    output rv32_pkg::reg_addr_t rs1,
    output rv32_pkg::reg_addr_t rs2,
    output logic                uses_rs1,
    output logic                uses_rs2,
    output rv32_pkg::reg_addr_t rd,
    output logic                reg_write,
    output rv32_pkg::word_t     imm,
    output rv32_pkg::alu_op_e   alu_op,
    output logic                alu_src_imm,
    output logic                zero_a,
    output rv32_pkg::branch_e   branch,
    output logic                is_jal,
    output logic                mem_read,
    output logic                mem_write,
    output rv32_pkg::wb_sel_e   wb_sel
);
    import rv32_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_j;
    word_t      imm_u;

    // funct7 bit 5 picks SUB and SRA, but only the shift uses it in I-type
    function automatic alu_op_e funct_to_alu(logic [2:0] f3, logic alt, logic reg_form);
        alu_op_e op;
        case (f3)
            3'b000:  op = (alt && reg_form) ? alu_sub : alu_add;
            3'b001:  op = alu_sll;
            3'b010:  op = alu_slt;
            3'b011:  op = alu_sltu;
            3'b100:  op = alu_xor;
            3'b101:  op = alt ? alu_sra : alu_srl;
            3'b110:  op = alu_or;
            default: op = alu_and;
        endcase
        return op;
    endfunction

    function automatic branch_e funct_to_branch(logic [2:0] f3);
        branch_e br;
        case (f3)
            3'b000:  br = br_eq;
            3'b001:  br = br_ne;
            3'b100:  br = br_lt;
            3'b101:  br = br_ge;
            3'b110:  br = br_ltu;
            3'b111:  br = br_geu;
            default: br = br_none;
        endcase
        return br;
    endfunction

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    // Immediate formats
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    always_comb begin
        uses_rs1    = 1'b0;
        uses_rs2    = 1'b0;
        reg_write   = 1'b0;
        imm         = '0;
        alu_op      = alu_add;
        alu_src_imm = 1'b0;
        zero_a      = 1'b0;
        branch      = br_none;
        is_jal      = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        wb_sel      = wb_alu;
        case (opcode)
            op_lui: begin
                // 0 + imm through the adder
                reg_write   = 1'b1;
                imm         = imm_u;
                alu_src_imm = 1'b1;
                zero_a      = 1'b1;
            end
            op_jal: begin
                reg_write = 1'b1;
                imm       = imm_j;
                is_jal    = 1'b1;
                wb_sel    = wb_pc4;
            end
            op_branch: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                imm      = imm_b;
                branch   = funct_to_branch(funct3);
            end
            op_load: begin
                uses_rs1    = 1'b1;
                reg_write   = 1'b1;
                imm         = imm_i;
                alu_src_imm = 1'b1;
                mem_read    = 1'b1;
                wb_sel      = wb_mem;
            end
            op_store: begin
                uses_rs1    = 1'b1;
                uses_rs2    = 1'b1;
                imm         = imm_s;
                alu_src_imm = 1'b1;
                mem_write   = 1'b1;
            end
            op_imm: begin
                uses_rs1    = 1'b1;
                reg_write   = 1'b1;
                imm         = imm_i;
                alu_src_imm = 1'b1;
                alu_op      = funct_to_alu(funct3, funct7[5], 1'b0);
            end
            op_reg: begin
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
                reg_write = 1'b1;
                alu_op    = funct_to_alu(funct3, funct7[5], 1'b1);
            end
            // Anything else runs as a NOP
            default: begin
            end
        endcase
    end

    // Later stages see no destination unless the register is written
    assign rd = reg_write ? instr[11:7] : '0;

endmodule

// ==== rv32_hazard_unit.sv ====
module rv32_hazard_unit (
    input  rv32_pkg::reg_addr_t id_rs1,
    input  rv32_pkg::reg_addr_t id_rs2,
    input  logic                id_uses_rs1,
    input  logic                id_uses_rs2,
    input  logic                id_is_control,
    input  rv32_pkg::reg_addr_t ex_rs1,
    input  rv32_pkg::reg_addr_t ex_rs2,
    input  rv32_pkg::reg_addr_t ex_rd,
    input  logic                ex_mem_read,
    input  rv32_pkg::reg_addr_t mem_rd,
    input  rv32_pkg::reg_addr_t wb_rd,
    output rv32_pkg::fwd_sel_e  fwd_a,
    output rv32_pkg::fwd_sel_e  fwd_b,
    output logic                branch_fwd_a,
    output logic                branch_fwd_b,
    output logic                stall
);
    import rv32_pkg::*;

    logic ex_hit_a;
    logic ex_hit_b;

    // The younger producer wins when MEM and WB both match
    function automatic fwd_sel_e pick_source(reg_addr_t src, reg_addr_t mem_dst,
                                             reg_addr_t wb_dst);
        fwd_sel_e sel;
        if (src == '0) begin
            sel = fwd_none;
        end else if (src == mem_dst) begin
            sel = fwd_mem;
        end else if (src == wb_dst) begin
            sel = fwd_wb;
        end else begin
            sel = fwd_none;
        end
        return sel;
    endfunction

    ////////////////////////////////////////
    // EXE operand forwarding
    ////////////////////////////////////////

    assign fwd_a = pick_source(ex_rs1, mem_rd, wb_rd);
    assign fwd_b = pick_source(ex_rs2, mem_rd, wb_rd);

    ////////////////////////////////////////
    // ID branch operands and stall
    ////////////////////////////////////////

    // WB needs no path here, the register file writes through
    assign branch_fwd_a = id_uses_rs1 && id_rs1 != '0 && id_rs1 == mem_rd;
    assign branch_fwd_b = id_uses_rs2 && id_rs2 != '0 && id_rs2 == mem_rd;

    assign ex_hit_a = id_uses_rs1 && id_rs1 != '0 && id_rs1 == ex_rd;
    assign ex_hit_b = id_uses_rs2 && id_rs2 != '0 && id_rs2 == ex_rd;

    // Load data is late for EXE, any EXE result is late for the ID compare
    assign stall = (ex_hit_a || ex_hit_b) && (ex_mem_read || id_is_control);

endmodule

// ==== rv32_pipe.f ====
+incdir+.
rv32_pkg.sv
rv32_alu.sv
rv32_regfile.sv
rv32_decoder.sv
rv32_hazard_unit.sv
rv32_cpu.sv
tb_rv32_cpu.sv

// ==== rv32_pkg.sv ====
package rv32_pkg;

    ////////////////////////////////////////
    // Widths and basic types
    ////////////////////////////////////////

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // addi x0, x0, 0
    localparam word_t nop_instr = 32'h0000_0013;

    ////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_jal    = 7'b1101111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_e;

    // Branch condition checked in ID
    typedef enum logic [2:0] {
        br_none,
        br_eq,
        br_ne,
        br_lt,
        br_ge,
        br_ltu,
        br_geu
    } branch_e;

    // Write-back source
    typedef enum logic [1:0] {
        wb_alu,
        wb_mem,
        wb_pc4
    } wb_sel_e;

    // Operand source in EXE
    typedef enum logic [1:0] {
        fwd_none,
        fwd_mem,
        fwd_wb
    } fwd_sel_e;

endpackage

// ==== rv32_regfile.sv ====
module rv32_regfile (
    input  logic                clk,
    input  logic                reset,
    input  rv32_pkg::reg_addr_t ra,
    input  rv32_pkg::reg_addr_t rb,
    input  rv32_pkg::reg_addr_t wa,
    input  logic                we,
    input  rv32_pkg::word_t     wd,
    output rv32_pkg::word_t     rda,
    output rv32_pkg::word_t     rdb
);
    import rv32_pkg::*;

    // x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    // Write-through, so ID sees the value retiring this cycle
    always_comb begin
        if (ra == '0) begin
            rda = '0;
        end else if (we && wa == ra) begin
            rda = wd;
        end else begin
            rda = regs[ra];
        end
    end

    always_comb begin
        if (rb == '0) begin
            rdb = '0;
        end else if (we && wa == rb) begin
            rdb = wd;
        end else begin
            rdb = regs[rb];
        end
    end

endmodule

// ==== tb_rv32_program.svh ====
`ifndef TB_RV32_PROGRAM_SVH
`define TB_RV32_PROGRAM_SVH

task automatic load_program();
    for (int i = 0; i < 64; i++) begin
        rom[i] = nop_instr;
    end
    // 0x00 dependent ALU chain
    append_instr(upper_imm(1, 'h12345));
    append_instr(imm_op(0, 2, 0, 100));
    append_instr(reg_op(0, 0, 3, 1, 2));
    append_instr(reg_op('h20, 0, 4, 3, 2));
    append_instr(reg_op(0, 4, 5, 4, 3));
    append_instr(store_word(3, 0, 128));
    append_instr(store_word(4, 0, 132));
    append_instr(store_word(5, 0, 136));
    // 0x20 SLT and SRA on a negative value
    append_instr(imm_op(0, 6, 0, -5));
    append_instr(reg_op(0, 2, 7, 6, 2));
    append_instr(reg_op('h20, 5, 8, 6, 7));
    append_instr(store_word(7, 0, 140));
    append_instr(store_word(8, 0, 144));
    append_instr(store_word(1, 0, 148));
    // 0x38 load-use
    append_instr(load_word(9, 0, 16));
    append_instr(imm_op(0, 10, 9, 'h123));
    append_instr(store_word(10, 0, 152));
    // x11 holds the wrong-path marker
    append_instr(upper_imm(11, 'hdeadc));
    append_instr(imm_op(0, 11, 11, -273));
    // 0x4c branch pairs, taken then not taken
    append_instr(branch_to(0, 2, 2, 8));
    append_instr(store_word(11, 0, 160));
    append_instr(branch_to(0, 2, 6, 8));
    append_instr(imm_op(0, 12, 12, 1));
    append_instr(branch_to(1, 2, 6, 8));
    append_instr(store_word(11, 0, 160));
    append_instr(branch_to(1, 2, 2, 8));
    append_instr(imm_op(0, 12, 12, 1));
    append_instr(branch_to(4, 6, 2, 8));
    append_instr(store_word(11, 0, 160));
    append_instr(branch_to(4, 2, 6, 8));
    append_instr(imm_op(0, 12, 12, 1));
    append_instr(branch_to(5, 2, 6, 8));
    append_instr(store_word(11, 0, 160));
    append_instr(branch_to(5, 6, 2, 8));
    append_instr(imm_op(0, 12, 12, 1));
    append_instr(branch_to(6, 2, 6, 8));
    append_instr(store_word(11, 0, 160));
    append_instr(branch_to(6, 6, 2, 8));
    append_instr(imm_op(0, 12, 12, 1));
    append_instr(branch_to(7, 6, 2, 8));
    append_instr(store_word(11, 0, 160));
    append_instr(branch_to(7, 2, 6, 8));
    append_instr(imm_op(0, 12, 12, 1));
    // 0xac branch on the result just before it
    append_instr(imm_op(0, 13, 2, 0));
    append_instr(branch_to(0, 13, 2, 8));
    append_instr(store_word(11, 0, 160));
    // 0xb8 JAL skips one marker store
    append_instr(jump_link(14, 8));
    append_instr(store_word(11, 0, 160));
    append_instr(store_word(14, 0, 164));
    append_instr(store_word(12, 0, 168));
    // 0xc8 final self-loop
    append_instr(jump_link(0, 0));
endtask

task automatic build_expected();
    n_expected = 0;
    expect_store(128, 32'h1234_5000 + 32'd100);
    expect_store(132, 32'h1234_5064 - 32'd100);
    expect_store(136, 32'h1234_5000 ^ 32'h1234_5064);
    // -5 < 100 signed
    expect_store(140, 32'd1);
    expect_store(144, 32'hffff_fffd);
    expect_store(148, 32'h1234_5000);
    expect_store(152, ram[4] + 32'h123);
    // Link of the JAL at 0xb8
    expect_store(164, 32'd184 + 32'd4);
    // One increment per branch not taken
    expect_store(168, 32'd6);
endtask

`endif

// ==== tb_rv32_cpu.sv ====
module tb_rv32_cpu;
    timeunit 1ns;
    timeprecision 100ps;

    import rv32_pkg::*;

    localparam word_t reset_pc     = 32'h0000_0000;
    localparam word_t final_pc     = 32'd200;
    localparam word_t marker       = 32'hdead_beef;
    localparam int    max_cycles   = 2000;

    logic   clk;
    logic   reset;
    logic   reset_q = 1'b0;
    word_t  inst_in;
    word_t  ram_data_in;
    word_t  pc_out;
    word_t  alu_out;
    word_t  data_out;
    logic   mem_w;

    word_t  rom [0:63];
    word_t  ram [0:63];
    int     prog_len = 0;
    integer seed;

    // Expected stores in program order
    word_t  exp_addr [0:15];
    word_t  exp_data [0:15];
    int     n_expected = 0;
    int     store_idx = 0;

    rv32_cpu #(
        .reset_pc (reset_pc)
    ) dut0 (
        .clk         (clk),
        .reset       (reset),
        .inst_in     (inst_in),
        .ram_data_in (ram_data_in),
        .pc_out      (pc_out),
        .alu_out     (alu_out),
        .data_out    (data_out),
        .mem_w       (mem_w)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////
    // Instruction encoders
    ////////////////////////////////////////

    function automatic word_t reg_op(int f7, int f3, int rd, int rs1, int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic word_t imm_op(int f3, int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0010011};
    endfunction

    function automatic word_t load_word(int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
    endfunction

    function automatic word_t store_word(int rs2, int rs1, int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t branch_to(int f3, int rs1, int rs2, int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
                7'b1100011};
    endfunction

    function automatic word_t jump_link(int rd, int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic word_t upper_imm(int rd, int imm20);
        return {imm20[19:0], rd[4:0], 7'b0110111};
    endfunction

    task automatic append_instr(word_t w);
        rom[prog_len] = w;
        prog_len++;
    endtask

    task automatic expect_store(word_t addr, word_t data);
        exp_addr[n_expected] = addr;
        exp_data[n_expected] = data;
        n_expected++;
    endtask

    function automatic bit run_complete();
        return store_idx == n_expected && pc_out == final_pc;
    endfunction

    `include "tb_rv32_program.svh"

    ////////////////////////////////////////
    // Memory models
    ////////////////////////////////////////

    assign inst_in     = rom[pc_out[7:2]];
    assign ram_data_in = ram[alu_out[7:2]];

    // Random contents first, then stores land on the falling edge
    initial begin
        seed = 32'ha497_2453;
        for (int i = 0; i < 64; i++) begin
            ram[i] = $random(seed);
        end
        forever begin
            @(negedge clk);
            if (mem_w) begin
                ram[alu_out[7:2]] = data_out;
            end
        end
    end

    always @(posedge clk) begin
        reset_q <= reset;
        if (mem_w) begin
            store_idx <= store_idx + 1;
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    assert property (@(posedge clk) reset_q |-> !mem_w)
        else begin
            $display("TEST FAILED");
            $display("Error mem_w: expected 0x0, got 0x%0h", $sampled(mem_w));
            $fatal(1);
        end

    // First cycle out of reset
    assert property (@(posedge clk) reset_q && !reset |-> pc_out == reset_pc)
        else begin
            $display("TEST FAILED");
            $display("Error pc_out: expected 0x%08h, got 0x%08h", reset_pc,
                     $sampled(pc_out));
            $fatal(1);
        end

    assert property (@(posedge clk) mem_w |-> data_out != marker)
        else begin
            $display("TEST FAILED");
            $display("A store on a flushed path reached memory at 0x%08h",
                     $sampled(alu_out));
            $fatal(1);
        end

    assert property (@(posedge clk) mem_w |-> store_idx < n_expected)
        else begin
            $display("TEST FAILED");
            $display("A store was seen after all expected stores were done");
            $fatal(1);
        end

    assert property (@(posedge clk) mem_w |-> alu_out == exp_addr[store_idx])
        else begin
            $display("TEST FAILED");
            $display("Error alu_out: expected 0x%08h, got 0x%08h",
                     $sampled(exp_addr[store_idx]), $sampled(alu_out));
            $fatal(1);
        end

    assert property (@(posedge clk) mem_w |-> data_out == exp_data[store_idx])
        else begin
            $display("TEST FAILED");
            $display("Error data_out: expected 0x%08h, got 0x%08h",
                     $sampled(exp_data[store_idx]), $sampled(data_out));
            $fatal(1);
        end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    initial begin
        int cycles;
        reset = 1'b1;
        load_program();
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // RAM is filled by now, so the load result is known
        build_expected();
        cycles = 0;
        while (!run_complete() && cycles < max_cycles) begin
            @(negedge clk);
            cycles++;
        end
        if (run_complete()) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("TEST FAILED");
            $display("Timeout waiting for all stores and the final loop, %0d of %0d stores",
                     store_idx, n_expected);
            $fatal(1);
        end
    end

endmodule
